//--- Bender.yml
package:
  name: cp2_decode_stage

sources:
  - common/cp2_pkg.sv
  - src/cp2_instr_decoder.sv
  - src/cp2_read_select.sv
  - src/cp2_issue_reg.sv
  - src/cp2_decode_stage.sv
  - target: simulation
    files:
      - verif/cp2_decode_stage_tb.sv

//--- common/cp2_pkg.sv
`default_nettype none

package cp2_pkg;

    ////////////////////
    // Widths
    typedef logic [31:0] word_t;
    typedef logic [5:0]  task_id_t;
    typedef logic [63:0] task_mask_t;
    typedef logic [6:0]  prio_t;
    typedef logic [4:0]  reg_num_t;
    typedef logic [2:0]  info_sel_t;
    typedef logic [4:0]  fmt_t;
    typedef logic [2:0]  sel_t;

    ////////////////////
    // Instruction encodings
    localparam fmt_t FMT_MFC2      = 5'd0;
    localparam fmt_t FMT_MTC2      = 5'd4;
    localparam fmt_t FMT_MTC2TC    = 5'd8;
    localparam fmt_t FMT_TINIT     = 5'd16;
    localparam fmt_t FMT_TDEL      = 5'd17;
    localparam fmt_t FMT_TTTASK    = 5'd18;
    localparam fmt_t FMT_DISTTTASK = 5'd19;
    localparam fmt_t FMT_CHTS      = 5'd20;

    localparam sel_t SEL_IO      = 3'd0;
    localparam sel_t SEL_TIME    = 3'd1;
    localparam sel_t SEL_TTR     = 3'd2;
    localparam sel_t SEL_TASK    = 3'd3;
    localparam sel_t SEL_TOPTASK = 3'd4;

    // Timer vs I/O register file
    localparam int TTR_SEL_BIT = 1;

    localparam info_sel_t INFO_CY       = 3'd0;
    localparam info_sel_t INFO_PH       = 3'd1;
    localparam info_sel_t INFO_DEADLINE = 3'd2;

    localparam logic [1:0] AORD_NONE = 2'd0;
    localparam logic [1:0] AORD_DEL  = 2'd2;
    localparam logic [1:0] AORD_INIT = 2'd3;

    // High bits of a timer-control register number
    localparam logic [1:0] TTR_TC_PREFIX = 2'd1;

    typedef enum logic [1:0] {SRC_TIME, SRC_TTR, SRC_TASK, SRC_TOP} read_src_e;
    typedef enum logic [1:0] {KIND_NONE, KIND_AS, KIND_FS, KIND_TS} cmd_kind_e;

    ////////////////////
    // Bundles
    typedef struct packed {
        read_src_e src;
        logic      time_info_sel;
        logic      top_sel;
        logic      ttr_r_sel;
        reg_num_t  ttr_r_number;
        logic      ttr_rea;
        info_sel_t task_info_sel;
        task_id_t  task_sel_r;
    } read_req_t;

    typedef struct packed {
        cmd_kind_e  kind;
        logic       as_result;
        task_id_t   task_sel;
        logic [1:0] aord_op;
        logic       g_time_write_en;
        logic       g_time_write_sel;
        logic       ttr_w_sel;
        reg_num_t   ttr_w_number;
        logic       ttr_wea;
        logic       chcy_ena;
        logic       chph_ena;
        logic       chdeadline_ena;
        logic       chs_ena;
        logic       new_status;
        logic       trigger_op_ena;
        logic       trigger_op;
    } task_cmd_t;

    typedef struct packed {
        task_id_t   task_sel;
        logic [1:0] aord_op;
        logic       g_time_write_en;
        logic       g_time_write_sel;
        logic       ttr_w_sel;
        reg_num_t   ttr_w_number;
        logic       ttr_wea;
        logic       chcy_ena;
        logic       chph_ena;
        logic       chdeadline_ena;
        logic       chs_ena;
        logic       new_status;
        logic       trigger_op_ena;
        logic       trigger_op;
    } issue_t;

endpackage

`default_nettype wire

//--- cp2_decode_stage.f
common/cp2_pkg.sv
src/cp2_instr_decoder.sv
src/cp2_read_select.sv
src/cp2_issue_reg.sv
src/cp2_decode_stage.sv
verif/cp2_decode_stage_tb.sv

//--- src/cp2_decode_stage.sv
`timescale 1ns/100ps
`default_nettype none

module cp2_decode_stage (
    input  wire                      clk,
    input  wire                      rst,
    input  wire                      decode_en,
    input  wire cp2_pkg::word_t      fetch_instruction,
    input  wire cp2_pkg::word_t      time_dout,
    input  wire cp2_pkg::word_t      ttr_dout,
    input  wire cp2_pkg::word_t      task_info,
    input  wire cp2_pkg::word_t      write_back_fwd,
    input  wire cp2_pkg::task_mask_t task_exist_list,
    input  wire cp2_pkg::prio_t      tt_top_pri_task,
    input  wire cp2_pkg::prio_t      et_top_pri_task,
    input  wire                      cp2_as_0,
    input  wire                      cp2_fs_0,
    input  wire                      cp2_ts_0,
    output wire cp2_pkg::read_req_t  read_req,
    output wire                      decode_as,
    output wire                      decode_fs,
    output wire                      decode_ts,
    output wire cp2_pkg::word_t      decode_fdata,
    output wire cp2_pkg::issue_t     decode_issue
);

    cp2_pkg::task_cmd_t cmd;
    cp2_pkg::word_t     result;

    cp2_instr_decoder u_decoder (
        .fetch_instruction(fetch_instruction),
        .task_exist_list  (task_exist_list),
        .read_req         (read_req),
        .cmd              (cmd)
    );

    // Read data comes back within the same cycle
    cp2_read_select u_read_select (
        .read_req       (read_req),
        .cmd            (cmd),
        .time_dout      (time_dout),
        .ttr_dout       (ttr_dout),
        .task_info      (task_info),
        .tt_top_pri_task(tt_top_pri_task),
        .et_top_pri_task(et_top_pri_task),
        .result         (result)
    );

    cp2_issue_reg u_issue_reg (
        .clk              (clk),
        .rst              (rst),
        .decode_en        (decode_en),
        .cp2_as_0         (cp2_as_0),
        .cp2_fs_0         (cp2_fs_0),
        .cp2_ts_0         (cp2_ts_0),
        .fetch_instruction(fetch_instruction),
        .result           (result),
        .write_back_fwd   (write_back_fwd),
        .cmd              (cmd),
        .decode_as        (decode_as),
        .decode_fs        (decode_fs),
        .decode_ts        (decode_ts),
        .decode_fdata     (decode_fdata),
        .decode_issue     (decode_issue)
    );

endmodule

`default_nettype wire

//--- src/cp2_instr_decoder.sv
`timescale 1ns/100ps
`default_nettype none

module cp2_instr_decoder (
    input  wire cp2_pkg::word_t      fetch_instruction,
    input  wire cp2_pkg::task_mask_t task_exist_list,
    output cp2_pkg::read_req_t       read_req,
    output cp2_pkg::task_cmd_t       cmd
);

    cp2_pkg::fmt_t     fmt;
    cp2_pkg::sel_t     sel;
    logic [12:0]       imm;
    cp2_pkg::task_id_t instr_task;
    logic              task_hit;

    assign fmt        = fetch_instruction[25:21];
    assign sel        = fetch_instruction[2:0];
    assign imm        = fetch_instruction[15:3];
    assign instr_task = fetch_instruction[5:0];
    assign task_hit   = task_exist_list[instr_task];

    always_comb begin
        read_req         = '0;
        read_req.src     = cp2_pkg::SRC_TIME;
        cmd              = '0;
        cmd.kind         = cp2_pkg::KIND_NONE;
        cmd.aord_op      = cp2_pkg::AORD_NONE;

        case (fmt)
            ////////////////////
            // Reads back to the core
            cp2_pkg::FMT_MFC2: begin
                cmd.kind = cp2_pkg::KIND_FS;
                case (sel)
                    cp2_pkg::SEL_TIME: begin
                        read_req.src           = cp2_pkg::SRC_TIME;
                        read_req.time_info_sel = imm[0];
                    end
                    cp2_pkg::SEL_IO,
                    cp2_pkg::SEL_TTR: begin
                        read_req.src          = cp2_pkg::SRC_TTR;
                        read_req.ttr_r_sel    = sel[cp2_pkg::TTR_SEL_BIT];
                        read_req.ttr_r_number = imm[4:0];
                        read_req.ttr_rea      = 1'b1;
                    end
                    cp2_pkg::SEL_TASK: begin
                        read_req.src           = cp2_pkg::SRC_TASK;
                        read_req.task_info_sel = imm[8:6];
                        read_req.task_sel_r    = imm[5:0];
                    end
                    cp2_pkg::SEL_TOPTASK: begin
                        read_req.src     = cp2_pkg::SRC_TOP;
                        read_req.top_sel = imm[0];
                    end
                    default: begin
                    end
                endcase
            end

            ////////////////////
            // Writes
            cp2_pkg::FMT_MTC2: begin
                cmd.kind = cp2_pkg::KIND_TS;
                case (sel)
                    cp2_pkg::SEL_TIME: begin
                        cmd.g_time_write_en  = 1'b1;
                        cmd.g_time_write_sel = imm[0];
                    end
                    cp2_pkg::SEL_IO,
                    cp2_pkg::SEL_TTR: begin
                        cmd.ttr_w_sel    = sel[cp2_pkg::TTR_SEL_BIT];
                        cmd.ttr_w_number = imm[4:0];
                        cmd.ttr_wea      = 1'b1;
                    end
                    cp2_pkg::SEL_TASK: begin
                        cmd.task_sel = imm[5:0];
                        case (cp2_pkg::info_sel_t'(imm[8:6]))
                            cp2_pkg::INFO_CY:       cmd.chcy_ena       = 1'b1;
                            cp2_pkg::INFO_PH:       cmd.chph_ena       = 1'b1;
                            cp2_pkg::INFO_DEADLINE: cmd.chdeadline_ena = 1'b1;
                            default: begin
                            end
                        endcase
                    end
                    default: begin
                    end
                endcase
            end
            cp2_pkg::FMT_MTC2TC: begin
                cmd.kind         = cp2_pkg::KIND_TS;
                cmd.ttr_w_sel    = 1'b1;
                cmd.ttr_w_number = {cp2_pkg::TTR_TC_PREFIX, imm[2:0]};
                cmd.ttr_wea      = 1'b1;
            end

            ////////////////////
            // Task operations
            cp2_pkg::FMT_TINIT: begin
                cmd.kind     = cp2_pkg::KIND_AS;
                cmd.task_sel = instr_task;
                cmd.aord_op  = cp2_pkg::AORD_INIT;
            end
            cp2_pkg::FMT_TDEL: begin
                cmd.kind     = cp2_pkg::KIND_AS;
                cmd.task_sel = instr_task;
                cmd.aord_op  = cp2_pkg::AORD_DEL;
            end
            cp2_pkg::FMT_TTTASK,
            cp2_pkg::FMT_DISTTTASK: begin
                cmd.kind = cp2_pkg::KIND_AS;
                if (task_hit) begin
                    cmd.task_sel       = instr_task;
                    cmd.trigger_op_ena = 1'b1;
                    cmd.trigger_op     = (fmt == cp2_pkg::FMT_TTTASK);
                    cmd.as_result      = 1'b1;
                end
            end
            cp2_pkg::FMT_CHTS: begin
                cmd.kind = cp2_pkg::KIND_AS;
                if (task_hit) begin
                    cmd.task_sel   = instr_task;
                    cmd.chs_ena    = 1'b1;
                    cmd.new_status = fetch_instruction[0];
                    cmd.as_result  = 1'b1;
                end
            end
            default: begin
            end
        endcase
    end

endmodule

`default_nettype wire

//--- src/cp2_issue_reg.sv
`timescale 1ns/100ps
`default_nettype none

module cp2_issue_reg (
    input  wire                     clk,
    input  wire                     rst,
    input  wire                     decode_en,
    input  wire                     cp2_as_0,
    input  wire                     cp2_fs_0,
    input  wire                     cp2_ts_0,
    input  wire cp2_pkg::word_t     fetch_instruction,
    input  wire cp2_pkg::word_t     result,
    input  wire cp2_pkg::word_t     write_back_fwd,
    input  wire cp2_pkg::task_cmd_t cmd,
    output logic                    decode_as,
    output logic                    decode_fs,
    output logic                    decode_ts,
    output cp2_pkg::word_t          decode_fdata,
    output cp2_pkg::issue_t         decode_issue
);

    cp2_pkg::word_t  prev_instr;
    logic            fwd_hit;
    logic            nxt_as;
    logic            nxt_fs;
    logic            nxt_ts;
    cp2_pkg::word_t  nxt_fdata;
    cp2_pkg::issue_t nxt_issue;

    always_ff @(posedge clk) begin
        prev_instr <= fetch_instruction;
    end

    // MFC2 right behind an MTC2 to the same location
    assign fwd_hit = (cp2_pkg::fmt_t'(prev_instr[25:21]) == cp2_pkg::FMT_MTC2)
                  && (fetch_instruction[15:0] == prev_instr[15:0])
                  && decode_ts;

    ////////////////////
    // Slot priority AS, FS, TS
    always_comb begin
        nxt_as    = 1'b0;
        nxt_fs    = 1'b0;
        nxt_ts    = 1'b0;
        nxt_fdata = '0;
        nxt_issue = '0;
        if (decode_en) begin
            if (cmd.kind == cp2_pkg::KIND_AS && cp2_as_0) begin
                nxt_as                   = 1'b1;
                nxt_fdata                = result;
                nxt_issue.task_sel       = cmd.task_sel;
                nxt_issue.aord_op        = cmd.aord_op;
                nxt_issue.chs_ena        = cmd.chs_ena;
                nxt_issue.new_status     = cmd.new_status;
                nxt_issue.trigger_op_ena = cmd.trigger_op_ena;
                nxt_issue.trigger_op     = cmd.trigger_op;
            end else if (cmd.kind == cp2_pkg::KIND_FS && cp2_fs_0) begin
                nxt_fs    = 1'b1;
                nxt_fdata = fwd_hit ? write_back_fwd : result;
            end else if (cmd.kind == cp2_pkg::KIND_TS && cp2_ts_0) begin
                nxt_ts                     = 1'b1;
                nxt_issue.task_sel         = cmd.task_sel;
                nxt_issue.g_time_write_en  = cmd.g_time_write_en;
                nxt_issue.g_time_write_sel = cmd.g_time_write_sel;
                nxt_issue.ttr_w_sel        = cmd.ttr_w_sel;
                nxt_issue.ttr_w_number     = cmd.ttr_w_number;
                nxt_issue.ttr_wea          = cmd.ttr_wea;
                nxt_issue.chcy_ena         = cmd.chcy_ena;
                nxt_issue.chph_ena         = cmd.chph_ena;
                nxt_issue.chdeadline_ena   = cmd.chdeadline_ena;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            decode_as    <= 1'b0;
            decode_fs    <= 1'b0;
            decode_ts    <= 1'b0;
            decode_fdata <= '0;
            decode_issue <= '0;
        end else begin
            decode_as    <= nxt_as;
            decode_fs    <= nxt_fs;
            decode_ts    <= nxt_ts;
            decode_fdata <= nxt_fdata;
            decode_issue <= nxt_issue;
        end
    end

    ////////////////////
    // Checks
    strobe_onehot_a: assert property (
        @(posedge clk) disable iff (rst)
        $onehot0({decode_as, decode_fs, decode_ts})
    ) else $error("more than one issue strobe high");

    reset_idle_a: assert property (
        @(posedge clk)
        rst |=> !(decode_as || decode_fs || decode_ts) && (decode_fdata == '0)
    ) else $error("issue outputs active after reset");

endmodule

`default_nettype wire

//--- src/cp2_read_select.sv
`timescale 1ns/100ps
`default_nettype none

module cp2_read_select (
    input  wire cp2_pkg::read_req_t read_req,
    input  wire cp2_pkg::task_cmd_t cmd,
    input  wire cp2_pkg::word_t     time_dout,
    input  wire cp2_pkg::word_t     ttr_dout,
    input  wire cp2_pkg::word_t     task_info,
    input  wire cp2_pkg::prio_t     tt_top_pri_task,
    input  wire cp2_pkg::prio_t     et_top_pri_task,
    output cp2_pkg::word_t          result
);

    cp2_pkg::prio_t top_pri;
    cp2_pkg::word_t top_word;
    cp2_pkg::word_t src_word;
    cp2_pkg::word_t as_word;

    // Event queue when top_sel is set
    assign top_pri  = read_req.top_sel ? et_top_pri_task : tt_top_pri_task;
    assign top_word = cp2_pkg::word_t'(top_pri);

    always_comb begin
        case (read_req.src)
            cp2_pkg::SRC_TIME: src_word = time_dout;
            cp2_pkg::SRC_TTR:  src_word = ttr_dout;
            cp2_pkg::SRC_TASK: src_word = task_info;
            cp2_pkg::SRC_TOP:  src_word = top_word;
            default:           src_word = time_dout;
        endcase
    end

    // Task ops return 1 when the task was found
    assign as_word = cmd.as_result ? cp2_pkg::word_t'(1) : '0;

    assign result = (cmd.kind == cp2_pkg::KIND_AS) ? as_word : src_word;

endmodule

`default_nettype wire

//--- verif/cp2_decode_stage_tb.sv
`timescale 1ns/100ps
`default_nettype none

module cp2_decode_stage_tb;

    // Reset 3, then 1 + 6 + 7 + 8 + 3 + 4 cycles of tests
    localparam int TEST_CYCLES = 32;
    localparam int CLK_PERIOD  = 40;

    logic                clk;
    logic                rst;
    logic                decode_en;
    cp2_pkg::word_t      fetch_instruction;
    cp2_pkg::word_t      time_dout;
    cp2_pkg::word_t      ttr_dout;
    cp2_pkg::word_t      task_info;
    cp2_pkg::word_t      write_back_fwd;
    cp2_pkg::task_mask_t task_exist_list;
    cp2_pkg::prio_t      tt_top_pri_task;
    cp2_pkg::prio_t      et_top_pri_task;
    logic                cp2_as_0;
    logic                cp2_fs_0;
    logic                cp2_ts_0;
    cp2_pkg::read_req_t  read_req;
    logic                decode_as;
    logic                decode_fs;
    logic                decode_ts;
    cp2_pkg::word_t      decode_fdata;
    cp2_pkg::issue_t     decode_issue;

    logic [31:0] rnd_state;
    int          err_count;
    int          test_count;
    int          test_err_start;
    string       test_name;

    cp2_decode_stage UUT (.*);

    always #(CLK_PERIOD / 2) clk = ~clk;

    ////////////////////
    // Helpers
    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    task automatic rand_word(output logic [31:0] w);
        rnd_state = lcg_next(rnd_state);
        w = rnd_state;
    endtask

    // COP2 opcode, fmt, rt unused, immediate, sel
    function automatic cp2_pkg::word_t cop2_instr(input cp2_pkg::fmt_t fmt,
                                                  input logic [12:0] imm,
                                                  input cp2_pkg::sel_t sel);
        return {6'b010010, fmt, 5'd0, imm, sel};
    endfunction

    function automatic cp2_pkg::word_t as_instr(input cp2_pkg::fmt_t fmt,
                                                input cp2_pkg::task_id_t id);
        return {6'b010010, fmt, 15'd0, id};
    endfunction

    task automatic tick();
        @(posedge clk);
        #2;
    endtask

    task automatic drive_instr(input cp2_pkg::word_t instr);
        fetch_instruction = instr;
        decode_en = 1'b1;
    endtask

    task automatic report_fail(input string msg);
        err_count++;
        $display("FAIL at %0t ns: %s", $time, msg);
    endtask

    task automatic start_test(input string name);
        test_name = name;
        test_err_start = err_count;
    endtask

    task automatic finish_test();
        test_count++;
        $display("[%0t] %s done, %0d errors", $time, test_name, err_count - test_err_start);
    endtask

    ////////////////////
    // Checkers
    task automatic check_word(input cp2_pkg::word_t got, input cp2_pkg::word_t exp_word,
                              input string msg);
        if (got !== exp_word)
            report_fail($sformatf("%s: fdata %h, expected %h", msg, got, exp_word));
    endtask

    task automatic check_issue(input cp2_pkg::issue_t got, input cp2_pkg::issue_t exp_issue,
                               input string msg);
        if (got !== exp_issue)
            report_fail($sformatf("%s: issue %h, expected %h", msg, got, exp_issue));
    endtask

    task automatic check_strobes(input cp2_pkg::cmd_kind_e kind, input string msg);
        logic [2:0] exp_bits;
        exp_bits = {kind == cp2_pkg::KIND_AS, kind == cp2_pkg::KIND_FS,
                    kind == cp2_pkg::KIND_TS};
        if ({decode_as, decode_fs, decode_ts} !== exp_bits)
            report_fail($sformatf("%s: as/fs/ts %b, expected %b", msg,
                                  {decode_as, decode_fs, decode_ts}, exp_bits));
    endtask

    task automatic check_read_req(input cp2_pkg::read_req_t got,
                                  input cp2_pkg::read_req_t exp_req, input string msg);
        if (got !== exp_req)
            report_fail($sformatf("%s: read_req %h, expected %h", msg, got, exp_req));
    endtask

    // One edge later the registered outputs are stable
    task automatic expect_issue(input cp2_pkg::cmd_kind_e kind, input cp2_pkg::issue_t exp_issue,
                                input cp2_pkg::word_t exp_data, input string msg);
        tick();
        check_strobes(kind, msg);
        check_issue(decode_issue, exp_issue, msg);
        check_word(decode_fdata, exp_data, msg);
    endtask

    ////////////////////
    // Tests
    task automatic test_reset_idle();
        start_test("reset_idle");
        check_strobes(cp2_pkg::KIND_NONE, "after reset");
        check_issue(decode_issue, '0, "after reset");
        check_word(decode_fdata, '0, "after reset");
        fetch_instruction = cop2_instr(cp2_pkg::FMT_MTC2, 13'h1, cp2_pkg::SEL_TIME);
        decode_en = 1'b0;
        expect_issue(cp2_pkg::KIND_NONE, '0, '0, "decode_en low");
        finish_test();
    endtask

    task automatic test_mfc2_reads();
        cp2_pkg::read_req_t exp_req;
        cp2_pkg::word_t     exp_data;
        cp2_pkg::sel_t      sel;
        logic [31:0]        r;
        logic [12:0]        imm;
        start_test("mfc2_reads");
        for (int i = 0; i < 6; i++) begin
            sel = (i < 4) ? cp2_pkg::sel_t'(i) : cp2_pkg::SEL_TOPTASK;
            rand_word(r);
            imm = r[12:0];
            if (i >= 4)
                imm[0] = i[0];
            rand_word(time_dout);
            rand_word(ttr_dout);
            rand_word(task_info);
            rand_word(r);
            tt_top_pri_task = r[6:0];
            et_top_pri_task = r[14:8];
            exp_req = '0;
            exp_req.src = cp2_pkg::SRC_TIME;
            exp_data = time_dout;
            case (sel)
                cp2_pkg::SEL_TIME: exp_req.time_info_sel = imm[0];
                cp2_pkg::SEL_IO, cp2_pkg::SEL_TTR: begin
                    exp_req.src = cp2_pkg::SRC_TTR;
                    exp_req.ttr_r_sel = (sel == cp2_pkg::SEL_TTR);
                    exp_req.ttr_r_number = imm[4:0];
                    exp_req.ttr_rea = 1'b1;
                    exp_data = ttr_dout;
                end
                cp2_pkg::SEL_TASK: begin
                    exp_req.src = cp2_pkg::SRC_TASK;
                    exp_req.task_info_sel = imm[8:6];
                    exp_req.task_sel_r = imm[5:0];
                    exp_data = task_info;
                end
                default: begin
                    exp_req.src = cp2_pkg::SRC_TOP;
                    exp_req.top_sel = imm[0];
                    exp_data = imm[0] ? {25'd0, et_top_pri_task} : {25'd0, tt_top_pri_task};
                end
            endcase
            drive_instr(cop2_instr(cp2_pkg::FMT_MFC2, imm, sel));
            #1;
            check_read_req(read_req, exp_req, $sformatf("mfc2 sel %0d", sel));
            expect_issue(cp2_pkg::KIND_FS, '0, exp_data, $sformatf("mfc2 sel %0d", sel));
        end
        finish_test();
    endtask

    task automatic test_mtc2_writes();
        cp2_pkg::issue_t exp_issue;
        logic [31:0]     r;
        logic [12:0]     imm;
        start_test("mtc2_writes");
        rand_word(r);
        imm = r[12:0];
        exp_issue = '0;
        exp_issue.g_time_write_en = 1'b1;
        exp_issue.g_time_write_sel = imm[0];
        drive_instr(cop2_instr(cp2_pkg::FMT_MTC2, imm, cp2_pkg::SEL_TIME));
        expect_issue(cp2_pkg::KIND_TS, exp_issue, '0, "mtc2 time");
        // I/O register first, then timer register
        for (int i = 0; i < 2; i++) begin
            rand_word(r);
            imm = r[12:0];
            exp_issue = '0;
            exp_issue.ttr_wea = 1'b1;
            exp_issue.ttr_w_sel = i[0];
            exp_issue.ttr_w_number = imm[4:0];
            drive_instr(cop2_instr(cp2_pkg::FMT_MTC2, imm,
                                   i ? cp2_pkg::SEL_TTR : cp2_pkg::SEL_IO));
            expect_issue(cp2_pkg::KIND_TS, exp_issue, '0, $sformatf("mtc2 reg %0d", i));
        end
        rand_word(r);
        imm = r[12:0];
        exp_issue = '0;
        exp_issue.ttr_wea = 1'b1;
        exp_issue.ttr_w_sel = 1'b1;
        exp_issue.ttr_w_number = {2'd1, imm[2:0]};
        drive_instr(cop2_instr(cp2_pkg::FMT_MTC2TC, imm, cp2_pkg::SEL_IO));
        expect_issue(cp2_pkg::KIND_TS, exp_issue, '0, "mtc2tc");
        for (int i = 0; i < 3; i++) begin
            rand_word(r);
            imm = r[12:0];
            imm[8:6] = 3'(i);
            exp_issue = '0;
            exp_issue.task_sel = imm[5:0];
            exp_issue.chcy_ena = (i == 0);
            exp_issue.chph_ena = (i == 1);
            exp_issue.chdeadline_ena = (i == 2);
            drive_instr(cop2_instr(cp2_pkg::FMT_MTC2, imm, cp2_pkg::SEL_TASK));
            expect_issue(cp2_pkg::KIND_TS, exp_issue, '0, $sformatf("mtc2 task %0d", i));
        end
        finish_test();
    endtask

    task automatic test_as_ops();
        cp2_pkg::issue_t   exp_issue;
        cp2_pkg::task_id_t hit_id;
        cp2_pkg::task_id_t miss_id;
        logic [31:0]       r;
        start_test("as_ops");
        rand_word(r);
        task_exist_list[31:0] = r;
        rand_word(r);
        task_exist_list[63:32] = r;
        rand_word(r);
        hit_id = r[5:0];
        miss_id = hit_id ^ 6'd1;
        task_exist_list[hit_id] = 1'b1;
        task_exist_list[miss_id] = 1'b0;
        exp_issue = '0;
        exp_issue.task_sel = hit_id;
        exp_issue.aord_op = cp2_pkg::AORD_INIT;
        drive_instr(as_instr(cp2_pkg::FMT_TINIT, hit_id));
        expect_issue(cp2_pkg::KIND_AS, exp_issue, '0, "tinit");
        exp_issue.task_sel = miss_id;
        exp_issue.aord_op = cp2_pkg::AORD_DEL;
        drive_instr(as_instr(cp2_pkg::FMT_TDEL, miss_id));
        expect_issue(cp2_pkg::KIND_AS, exp_issue, '0, "tdel");
        exp_issue = '0;
        exp_issue.task_sel = hit_id;
        exp_issue.trigger_op_ena = 1'b1;
        exp_issue.trigger_op = 1'b1;
        drive_instr(as_instr(cp2_pkg::FMT_TTTASK, hit_id));
        expect_issue(cp2_pkg::KIND_AS, exp_issue, 32'd1, "tttask hit");
        exp_issue.trigger_op = 1'b0;
        drive_instr(as_instr(cp2_pkg::FMT_DISTTTASK, hit_id));
        expect_issue(cp2_pkg::KIND_AS, exp_issue, 32'd1, "disttask hit");
        exp_issue = '0;
        exp_issue.task_sel = hit_id;
        exp_issue.chs_ena = 1'b1;
        exp_issue.new_status = hit_id[0];
        drive_instr(as_instr(cp2_pkg::FMT_CHTS, hit_id));
        expect_issue(cp2_pkg::KIND_AS, exp_issue, 32'd1, "chts hit");
        // Missing task issues but does nothing
        drive_instr(as_instr(cp2_pkg::FMT_TTTASK, miss_id));
        expect_issue(cp2_pkg::KIND_AS, '0, '0, "tttask miss");
        drive_instr(as_instr(cp2_pkg::FMT_DISTTTASK, miss_id));
        expect_issue(cp2_pkg::KIND_AS, '0, '0, "disttask miss");
        drive_instr(as_instr(cp2_pkg::FMT_CHTS, miss_id));
        expect_issue(cp2_pkg::KIND_AS, '0, '0, "chts miss");
        finish_test();
    endtask

    task automatic test_slot_gating();
        start_test("slot_gating");
        cp2_fs_0 = 1'b0;
        drive_instr(cop2_instr(cp2_pkg::FMT_MFC2, 13'h5, cp2_pkg::SEL_TIME));
        expect_issue(cp2_pkg::KIND_NONE, '0, '0, "fs slot low");
        cp2_fs_0 = 1'b1;
        cp2_ts_0 = 1'b0;
        drive_instr(cop2_instr(cp2_pkg::FMT_MTC2, 13'h3, cp2_pkg::SEL_TTR));
        expect_issue(cp2_pkg::KIND_NONE, '0, '0, "ts slot low");
        cp2_ts_0 = 1'b1;
        cp2_as_0 = 1'b0;
        task_exist_list[5] = 1'b1;
        drive_instr(as_instr(cp2_pkg::FMT_TTTASK, 6'd5));
        expect_issue(cp2_pkg::KIND_NONE, '0, '0, "as slot low");
        cp2_as_0 = 1'b1;
        finish_test();
    endtask

    task automatic test_forwarding();
        cp2_pkg::issue_t exp_issue;
        logic [31:0]     r;
        logic [12:0]     imm;
        start_test("forwarding");
        rand_word(ttr_dout);
        write_back_fwd = ~ttr_dout;
        rand_word(r);
        imm = r[12:0];
        exp_issue = '0;
        exp_issue.ttr_wea = 1'b1;
        exp_issue.ttr_w_sel = 1'b1;
        exp_issue.ttr_w_number = imm[4:0];
        drive_instr(cop2_instr(cp2_pkg::FMT_MTC2, imm, cp2_pkg::SEL_TTR));
        expect_issue(cp2_pkg::KIND_TS, exp_issue, '0, "fwd write");
        drive_instr(cop2_instr(cp2_pkg::FMT_MFC2, imm, cp2_pkg::SEL_TTR));
        expect_issue(cp2_pkg::KIND_FS, '0, write_back_fwd, "fwd same location");
        drive_instr(cop2_instr(cp2_pkg::FMT_MTC2, imm, cp2_pkg::SEL_TTR));
        expect_issue(cp2_pkg::KIND_TS, exp_issue, '0, "fwd write again");
        drive_instr(cop2_instr(cp2_pkg::FMT_MFC2, imm ^ 13'h1, cp2_pkg::SEL_TTR));
        expect_issue(cp2_pkg::KIND_FS, '0, ttr_dout, "fwd other location");
        finish_test();
    endtask

    ////////////////////
    // Sequence
    initial begin
        clk = 1'b0;
        rst = 1'b1;
        rnd_state = 32'd76864;
        err_count = 0;
        test_count = 0;
        decode_en = 1'b0;
        fetch_instruction = '0;
        time_dout = '0;
        ttr_dout = '0;
        task_info = '0;
        write_back_fwd = '0;
        task_exist_list = '0;
        tt_top_pri_task = '0;
        et_top_pri_task = '0;
        cp2_as_0 = 1'b1;
        cp2_fs_0 = 1'b1;
        cp2_ts_0 = 1'b1;
        repeat (3) @(posedge clk);
        #2;
        rst = 1'b0;
        test_reset_idle();
        test_mfc2_reads();
        test_mtc2_writes();
        test_as_ops();
        test_slot_gating();
        test_forwarding();
        $display("%0d tests run, %0d errors", test_count, err_count);
        if (err_count == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

    initial begin
        #((TEST_CYCLES + 10) * CLK_PERIOD);
        $display("Watchdog expired before the tests finished");
        $display("tests failed");
        $finish;
    end

endmodule

`default_nettype wire
